// File: pmp_pkg.sv
package pmp_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int PMP_ENTRIES    = 8;
  localparam int XLEN           = 64;

  // Address stores write-data bits 37:9
  localparam int PMP_ADDR_WIDTH = 29;
  localparam int PMP_ADDR_LSB   = 9;

  // One configuration byte per entry inside pmpcfg0
  localparam int PMP_CFG_BITS   = 8;

  // --------------------------------------------------
  // CSR select and write-enable layout
  // --------------------------------------------------
  localparam int PMP_CSR_NUM    = 9;
  localparam int PMP_SEL_CFG0   = 0;
  // pmpaddr0..pmpaddr7 follow on consecutive bits
  localparam int PMP_SEL_ADDR0  = 1;

  // --------------------------------------------------
  // Field types
  // --------------------------------------------------
  // Address-matching mode
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pmp_amode_e;

  // Configuration byte, most significant field first
  typedef struct packed {
    logic       lock;
    logic [1:0] rsvd;
    pmp_amode_e mode;
    logic       x;
    logic       w;
    logic       r;
  } pmp_cfg_t;

  typedef logic [PMP_ADDR_WIDTH-1:0] pmp_addr_t;

endpackage

// File: pmp_entry_if.sv
`timescale 1ns/100ps

interface pmp_entry_if;

  // Write strobes, one cycle wide
  logic                cfg_wen;
  logic                addr_wen;

  // Write fields from the CSR data
  pmp_pkg::pmp_cfg_t   cfg_wdata;
  pmp_pkg::pmp_addr_t  addr_wdata;

  // Stored values of the entry
  pmp_pkg::pmp_cfg_t   cfg;
  pmp_pkg::pmp_addr_t  addr;

  // Write decoder side, sees cfg for the TOR lock of the entry below
  modport decode (
    output cfg_wen,
    output addr_wen,
    output cfg_wdata,
    output addr_wdata,
    input  cfg
  );

  modport entry (
    input  cfg_wen,
    input  addr_wen,
    input  cfg_wdata,
    input  addr_wdata,
    output cfg,
    output addr
  );

  modport readout (
    input  cfg,
    input  addr
  );

endinterface

// File: pmp_csr_decode.sv
`timescale 1ns/100ps

module pmp_csr_decode (
  input  logic [pmp_pkg::XLEN-1:0]        cp0_pmp_wdata,
  input  logic [pmp_pkg::PMP_CSR_NUM-1:0] pmp_csr_wen,
  pmp_entry_if.decode                     ent [pmp_pkg::PMP_ENTRIES]
);

  // Address field shared by all pmpaddr writes
  pmp_pkg::pmp_addr_t              addr_field;

  // Next entry locked in TOR mode, freezes this address
  logic [pmp_pkg::PMP_ENTRIES-1:0] next_tor_lock;

  assign addr_field = cp0_pmp_wdata[pmp_pkg::PMP_ADDR_LSB +: pmp_pkg::PMP_ADDR_WIDTH];

  // --------------------------------------------------
  // Per-entry write strobes and fields
  // --------------------------------------------------
  genvar i;
  generate
    for (i = 0; i < pmp_pkg::PMP_ENTRIES; i++)
    begin : g_ent
      // One pmpcfg0 write reaches every byte
      assign ent[i].cfg_wen   = pmp_csr_wen[pmp_pkg::PMP_SEL_CFG0];
      assign ent[i].cfg_wdata = pmp_pkg::pmp_cfg_t'(
        cp0_pmp_wdata[i*pmp_pkg::PMP_CFG_BITS +: pmp_pkg::PMP_CFG_BITS]);

      if (i < pmp_pkg::PMP_ENTRIES - 1)
      begin : g_next
        assign next_tor_lock[i] = ent[i+1].cfg.lock
                                  && (ent[i+1].cfg.mode == pmp_pkg::TOR);
      end
      else
      begin : g_last
        // Top entry has no upper neighbour
        assign next_tor_lock[i] = 1'b0;
      end

      // Own lock is checked inside the entry
      assign ent[i].addr_wen   = pmp_csr_wen[pmp_pkg::PMP_SEL_ADDR0 + i]
                                 && !next_tor_lock[i];
      assign ent[i].addr_wdata = addr_field;
    end
  endgenerate

endmodule

// File: pmp_entry.sv
`timescale 1ns/100ps

module pmp_entry (
  input  logic       cpuclk,
  input  logic       cpurst_b,
  pmp_entry_if.entry ent
);

  logic                cfg_lock;
  pmp_pkg::pmp_amode_e cfg_mode;
  logic                cfg_x;
  logic                cfg_w;
  logic                cfg_r;
  pmp_pkg::pmp_addr_t  addr_q;

  logic                cfg_upd;
  logic                addr_upd;

  // Own lock blocks both registers until reset
  assign cfg_upd  = ent.cfg_wen && !cfg_lock;
  assign addr_upd = ent.addr_wen && !cfg_lock;

  // --------------------------------------------------
  // Configuration byte
  // --------------------------------------------------
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cfg_lock <= 1'b0;
      cfg_mode <= pmp_pkg::OFF;
      cfg_x    <= 1'b0;
      cfg_w    <= 1'b0;
      cfg_r    <= 1'b0;
    end
    else if (cfg_upd)
    begin
      cfg_lock <= ent.cfg_wdata.lock;
      cfg_mode <= ent.cfg_wdata.mode;
      cfg_x    <= ent.cfg_wdata.x;
      cfg_w    <= ent.cfg_wdata.w;
      cfg_r    <= ent.cfg_wdata.r;
    end
  end

  // --------------------------------------------------
  // Address register
  // --------------------------------------------------
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      addr_q <= '0;
    else if (addr_upd)
      addr_q <= ent.addr_wdata;
  end

  // Reserved bits always read zero
  assign ent.cfg  = '{lock: cfg_lock, rsvd: 2'b00, mode: cfg_mode,
                      x: cfg_x, w: cfg_w, r: cfg_r};
  assign ent.addr = addr_q;

endmodule

// File: pmp_read_mux.sv
`timescale 1ns/100ps

module pmp_read_mux (
  input  logic [pmp_pkg::PMP_CSR_NUM-1:0] pmp_csr_sel,
  pmp_entry_if.readout                    ent [pmp_pkg::PMP_ENTRIES],
  output logic [pmp_pkg::XLEN-1:0]        pmpcfg0_value,
  output logic [pmp_pkg::XLEN-1:0]        pmp_cp0_data
);

  localparam int ADDR_TOP_ZEROS = pmp_pkg::XLEN - pmp_pkg::PMP_ADDR_WIDTH
                                  - pmp_pkg::PMP_ADDR_LSB;

  // Addresses at their CSR bit positions
  logic [pmp_pkg::XLEN-1:0] addr_img [pmp_pkg::PMP_ENTRIES];

  // --------------------------------------------------
  // pmpcfg0 packing and address images
  // --------------------------------------------------
  genvar i;
  generate
    for (i = 0; i < pmp_pkg::PMP_ENTRIES; i++)
    begin : g_img
      // Entry 0 in the lowest byte, bits 6:5 forced to zero
      assign pmpcfg0_value[i*pmp_pkg::PMP_CFG_BITS +: pmp_pkg::PMP_CFG_BITS] =
        {ent[i].cfg.lock, 2'b00, ent[i].cfg.mode,
         ent[i].cfg.x, ent[i].cfg.w, ent[i].cfg.r};

      assign addr_img[i] = {{ADDR_TOP_ZEROS{1'b0}},
                            ent[i].addr,
                            {pmp_pkg::PMP_ADDR_LSB{1'b0}}};
    end
  endgenerate

  // --------------------------------------------------
  // One-hot AND-OR read
  // --------------------------------------------------
  always_comb
  begin
    pmp_cp0_data = {pmp_pkg::XLEN{pmp_csr_sel[pmp_pkg::PMP_SEL_CFG0]}}
                   & pmpcfg0_value;
    for (int k = 0; k < pmp_pkg::PMP_ENTRIES; k++)
    begin
      pmp_cp0_data = pmp_cp0_data
                     | ({pmp_pkg::XLEN{pmp_csr_sel[pmp_pkg::PMP_SEL_ADDR0 + k]}}
                        & addr_img[k]);
    end
  end

endmodule

// File: ct_pmp_regs.sv
`timescale 1ns/100ps

module ct_pmp_regs (
  input  logic                            cpuclk,
  input  logic                            cpurst_b,
  input  logic [pmp_pkg::XLEN-1:0]        cp0_pmp_wdata,
  input  logic [pmp_pkg::PMP_CSR_NUM-1:0] pmp_csr_sel,
  input  logic [pmp_pkg::PMP_CSR_NUM-1:0] pmp_csr_wen,
  output logic [pmp_pkg::XLEN-1:0]        pmp_cp0_data,
  output logic [pmp_pkg::XLEN-1:0]        pmpcfg0_value,
  output pmp_pkg::pmp_addr_t              pmpaddr_value [pmp_pkg::PMP_ENTRIES]
);

  // One link per entry between decoder, entry and read mux
  pmp_entry_if ent [pmp_pkg::PMP_ENTRIES] ();

  // --------------------------------------------------
  // Write decode with TOR lock
  // --------------------------------------------------
  pmp_csr_decode u_decode (
    .cp0_pmp_wdata (cp0_pmp_wdata),
    .pmp_csr_wen   (pmp_csr_wen),
    .ent           (ent)
  );

  // --------------------------------------------------
  // Entry registers
  // --------------------------------------------------
  genvar i;
  generate
    for (i = 0; i < pmp_pkg::PMP_ENTRIES; i++)
    begin : g_entry
      pmp_entry u_entry (
        .cpuclk   (cpuclk),
        .cpurst_b (cpurst_b),
        .ent      (ent[i])
      );

      assign pmpaddr_value[i] = ent[i].addr;
    end
  endgenerate

  // --------------------------------------------------
  // CSR read path
  // --------------------------------------------------
  pmp_read_mux u_read_mux (
    .pmp_csr_sel   (pmp_csr_sel),
    .ent           (ent),
    .pmpcfg0_value (pmpcfg0_value),
    .pmp_cp0_data  (pmp_cp0_data)
  );

endmodule

// File: tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
  parameter int CLK_PERIOD = 40,
  parameter int RST_CYCLES = 4
) (
  output logic cpuclk,
  output logic cpurst_b
);

  // Free-running clock
  initial
  begin
    cpuclk = 1'b0;
    forever #(CLK_PERIOD / 2) cpuclk = ~cpuclk;
  end

  // Reset held low for the first few rising edges
  initial
  begin
    cpurst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge cpuclk);
    cpurst_b <= 1'b1;
  end

endmodule

// File: tb_ct_pmp_regs.sv
`timescale 1ns/100ps

module tb_ct_pmp_regs;

  localparam int          CLK_PERIOD = 40;
  localparam int          RST_CYCLES = 4;
  localparam logic [31:0] SEED       = 32'hec7b;
  localparam logic [63:0] LOCK_MASK  = 64'h8080_8080_8080_8080;

  // Cycles spent by each test
  localparam int RESET_LEN = pmp_pkg::PMP_CSR_NUM;
  localparam int CFG_LEN   = 16;
  localparam int ADDR_LEN  = 16;
  localparam int LOCK_LEN  = 11;
  localparam int TOR_LEN   = 10;
  localparam int RAND_OPS  = 200;
  localparam int RAND_LEN  = RAND_OPS + 1;
  localparam int LIMIT     = 2 * (RST_CYCLES + RESET_LEN + CFG_LEN + ADDR_LEN
                                  + LOCK_LEN + TOR_LEN + RAND_LEN);

  logic                            cpuclk;
  logic                            cpurst_b;
  logic [pmp_pkg::XLEN-1:0]        cp0_pmp_wdata;
  logic [pmp_pkg::PMP_CSR_NUM-1:0] pmp_csr_sel;
  logic [pmp_pkg::PMP_CSR_NUM-1:0] pmp_csr_wen;
  logic [pmp_pkg::XLEN-1:0]        pmp_cp0_data;
  logic [pmp_pkg::XLEN-1:0]        pmpcfg0_value;
  pmp_pkg::pmp_addr_t              pmpaddr_value [pmp_pkg::PMP_ENTRIES];

  // Reference model state
  logic [pmp_pkg::PMP_CFG_BITS-1:0] cfg_m  [pmp_pkg::PMP_ENTRIES];
  pmp_pkg::pmp_addr_t               addr_m [pmp_pkg::PMP_ENTRIES];
  logic [pmp_pkg::PMP_CSR_NUM-1:0]  pend_wen;
  logic [pmp_pkg::XLEN-1:0]         pend_wdata;

  string cur_test;
  int    cur_checks;
  int    cur_errs;
  int    total_checks;
  int    total_errs;
  int    tests_run;
  int    tests_failed;
  int    cycles = 0;

  tb_clkgen #(.CLK_PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clkgen (
    .cpuclk   (cpuclk),
    .cpurst_b (cpurst_b)
  );

  ct_pmp_regs UUT (
    .cpuclk        (cpuclk),
    .cpurst_b      (cpurst_b),
    .cp0_pmp_wdata (cp0_pmp_wdata),
    .pmp_csr_sel   (pmp_csr_sel),
    .pmp_csr_wen   (pmp_csr_wen),
    .pmp_cp0_data  (pmp_cp0_data),
    .pmpcfg0_value (pmpcfg0_value),
    .pmpaddr_value (pmpaddr_value)
  );

  // Run limit
  always @(posedge cpuclk)
  begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Model and checking
  // --------------------------------------------------
  function automatic logic [pmp_pkg::PMP_CSR_NUM-1:0] csr_bit(input int idx);
    logic [pmp_pkg::PMP_CSR_NUM-1:0] v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  // Addresses use the lock state from before the edge
  task automatic apply_write(input logic [pmp_pkg::PMP_CSR_NUM-1:0] wen,
                             input logic [pmp_pkg::XLEN-1:0]        wdata);
    logic [pmp_pkg::PMP_ENTRIES:0] tor_above;
    tor_above = '0;
    for (int i = 0; i < pmp_pkg::PMP_ENTRIES; i++)
      tor_above[i] = cfg_m[i][7] && (cfg_m[i][4:3] == pmp_pkg::TOR);
    for (int i = 0; i < pmp_pkg::PMP_ENTRIES; i++)
    begin
      if (wen[pmp_pkg::PMP_SEL_ADDR0 + i] && !cfg_m[i][7] && !tor_above[i+1])
        addr_m[i] = wdata[pmp_pkg::PMP_ADDR_LSB +: pmp_pkg::PMP_ADDR_WIDTH];
    end
    if (wen[pmp_pkg::PMP_SEL_CFG0])
    begin
      for (int i = 0; i < pmp_pkg::PMP_ENTRIES; i++)
        if (!cfg_m[i][7])
          cfg_m[i] = wdata[i*8 +: 8] & 8'h9F;
    end
  endtask

  task automatic mismatch(input string what, input logic [63:0] exp,
                          input logic [63:0] act);
    $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
    cur_errs++;
    total_errs++;
  endtask

  task automatic check_outputs(input logic [pmp_pkg::PMP_CSR_NUM-1:0] sel);
    logic [pmp_pkg::XLEN-1:0] exp_cfg;
    logic [pmp_pkg::XLEN-1:0] exp_rd;
    logic [pmp_pkg::XLEN-1:0] img;
    exp_cfg = '0;
    for (int i = 0; i < pmp_pkg::PMP_ENTRIES; i++)
      exp_cfg[i*8 +: 8] = cfg_m[i];
    exp_rd = sel[pmp_pkg::PMP_SEL_CFG0] ? exp_cfg : '0;
    for (int i = 0; i < pmp_pkg::PMP_ENTRIES; i++)
    begin
      img = '0;
      img[pmp_pkg::PMP_ADDR_LSB +: pmp_pkg::PMP_ADDR_WIDTH] = addr_m[i];
      if (sel[pmp_pkg::PMP_SEL_ADDR0 + i])
        exp_rd = exp_rd | img;
      cur_checks++;
      if (pmpaddr_value[i] !== addr_m[i])
        mismatch($sformatf("pmpaddr_value[%0d]", i), 64'(addr_m[i]),
                 64'(pmpaddr_value[i]));
    end
    cur_checks += 2;
    if (pmpcfg0_value !== exp_cfg)
      mismatch("pmpcfg0_value", exp_cfg, pmpcfg0_value);
    if (pmp_cp0_data !== exp_rd)
      mismatch($sformatf("pmp_cp0_data sel=%b", sel), exp_rd, pmp_cp0_data);
  endtask

  // One cycle: drive at the rising edge, check at the falling edge
  task automatic access(input logic [pmp_pkg::PMP_CSR_NUM-1:0] wen,
                        input logic [pmp_pkg::PMP_CSR_NUM-1:0] sel,
                        input logic [pmp_pkg::XLEN-1:0]        wdata);
    @(posedge cpuclk);
    apply_write(pend_wen, pend_wdata);
    pmp_csr_wen   <= wen;
    pmp_csr_sel   <= sel;
    cp0_pmp_wdata <= wdata;
    pend_wen   = wen;
    pend_wdata = wdata;
    @(negedge cpuclk);
    check_outputs(sel);
  endtask

  task automatic start_test(input string name);
    cur_test   = name;
    cur_checks = 0;
    cur_errs   = 0;
  endtask

  task automatic end_test();
    $display("Test %-12s %0d checks, %0d errors", cur_test, cur_checks, cur_errs);
    tests_run++;
    total_checks += cur_checks;
    if (cur_errs != 0)
      tests_failed++;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin
    logic [63:0] d;
    int          e;
    int          j;
    int          t;
    int          b;
    pmp_csr_wen   = '0;
    pmp_csr_sel   = '0;
    cp0_pmp_wdata = '0;
    pend_wen      = '0;
    pend_wdata    = '0;
    total_checks  = 0;
    total_errs    = 0;
    tests_run     = 0;
    tests_failed  = 0;
    for (int i = 0; i < pmp_pkg::PMP_ENTRIES; i++)
    begin
      cfg_m[i]  = '0;
      addr_m[i] = '0;
    end
    void'($urandom(SEED));
    wait (cpurst_b === 1'b1);

    // Every CSR reads zero after reset
    start_test("reset");
    for (int k = 0; k < pmp_pkg::PMP_CSR_NUM; k++)
      access('0, csr_bit(k), '0);
    end_test();

    start_test("cfg_write");
    for (int k = 0; k < CFG_LEN / 2; k++)
    begin
      d = {$urandom, $urandom} & ~LOCK_MASK;
      access(csr_bit(pmp_pkg::PMP_SEL_CFG0), csr_bit(pmp_pkg::PMP_SEL_CFG0), d);
      access('0, csr_bit(pmp_pkg::PMP_SEL_CFG0), '0);
    end
    end_test();

    start_test("addr_write");
    for (int k = 0; k < pmp_pkg::PMP_ENTRIES; k++)
    begin
      d = {$urandom, $urandom};
      access(csr_bit(pmp_pkg::PMP_SEL_ADDR0 + k), csr_bit(pmp_pkg::PMP_SEL_ADDR0 + k), d);
      access('0, csr_bit(pmp_pkg::PMP_SEL_ADDR0 + k), '0);
    end
    end_test();

    // Lock entry e in OFF mode, then try to change it
    // Entry 7 stays unlocked for the TOR test
    start_test("own_lock");
    e = int'($urandom % 7);
    d = {$urandom, $urandom} & ~LOCK_MASK;
    d[e*8 +: 8] = 8'h80 | (d[e*8 +: 8] & 8'h07);
    access(csr_bit(pmp_pkg::PMP_SEL_CFG0), csr_bit(pmp_pkg::PMP_SEL_CFG0), d);
    access('0, csr_bit(pmp_pkg::PMP_SEL_CFG0), '0);
    for (int k = 0; k < 4; k++)
    begin
      d = {$urandom, $urandom} & ~LOCK_MASK;
      access(csr_bit(pmp_pkg::PMP_SEL_CFG0), csr_bit(pmp_pkg::PMP_SEL_CFG0), d);
      d = {$urandom, $urandom};
      access(csr_bit(pmp_pkg::PMP_SEL_ADDR0 + e), csr_bit(pmp_pkg::PMP_SEL_ADDR0 + e), d);
    end
    access('0, csr_bit(pmp_pkg::PMP_SEL_ADDR0 + e), '0);
    end_test();

    // Entry j locked in TOR freezes address j-1
    // Entry 7 unlocked, so its address write must land
    start_test("tor_lock");
    do
      j = 1 + int'($urandom % 6);
    while (j == e || j - 1 == e);
    d = {$urandom, $urandom} & ~LOCK_MASK;
    d[j*8 +: 8] = 8'h88 | (d[j*8 +: 8] & 8'h07);
    access(csr_bit(pmp_pkg::PMP_SEL_CFG0), csr_bit(pmp_pkg::PMP_SEL_CFG0), d);
    access('0, csr_bit(pmp_pkg::PMP_SEL_ADDR0 + j - 1), '0);
    for (int k = 0; k < 3; k++)
    begin
      d = {$urandom, $urandom};
      access(csr_bit(pmp_pkg::PMP_SEL_ADDR0 + j - 1),
             csr_bit(pmp_pkg::PMP_SEL_ADDR0 + j - 1), d);
      access('0, csr_bit(pmp_pkg::PMP_SEL_ADDR0 + j - 1), '0);
    end
    d = {$urandom, $urandom};
    access(csr_bit(pmp_pkg::PMP_SEL_ADDR0 + 7), csr_bit(pmp_pkg::PMP_SEL_ADDR0 + 7), d);
    access('0, csr_bit(pmp_pkg::PMP_SEL_ADDR0 + 7), '0);
    end_test();

    // Mixed accesses, a lock bit now and then
    start_test("random");
    for (int n = 0; n < RAND_OPS; n++)
    begin
      t = int'($urandom % 10);
      d = {$urandom, $urandom} & ~LOCK_MASK;
      if ($urandom % 8 == 0)
      begin
        b = int'($urandom % 8);
        d[b*8 + 7] = 1'b1;
      end
      access((t < pmp_pkg::PMP_CSR_NUM) ? csr_bit(t) : '0,
             csr_bit(int'($urandom % 9)), d);
    end
    access('0, csr_bit(pmp_pkg::PMP_SEL_CFG0), '0);
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, total_checks, total_errs);
    if (total_errs == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: ct_pmp_regs.f
pmp_pkg.sv
pmp_entry_if.sv
pmp_csr_decode.sv
pmp_entry.sv
pmp_read_mux.sv
ct_pmp_regs.sv
tb_clkgen.sv
tb_ct_pmp_regs.sv

// File: Makefile
# Verilator build and run for the PMP CSR block

VERILATOR ?= verilator
TOP       ?= tb_ct_pmp_regs
RTL_TOP   ?= ct_pmp_regs
FILELIST  ?= ct_pmp_regs.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --timing -j 0
PASS_MSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Status comes from the pass line in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
